/* logic/zxbus_pkg.sv */
package zxbus_pkg;

   // ----------------------------------------------------------------------
   // CPU side of the register bank
   // ----------------------------------------------------------------------

   // One Z80 I/O cycle, reduced to a single-clock strobe
   typedef struct packed {
      logic        valid;  // Strobe, high for one clock
      logic        write;  // OUT when set, IN otherwise
      logic [15:0] addr;   // Full 16-bit port address
      logic [7:0]  data;   // Byte written by the CPU
   } cpu_cycle_t;

   // One candidate for the CPU read data
   typedef struct packed {
      logic       hit;   // Source claims this read
      logic [7:0] data;
   } rd_src_t;

   // Access to the ZX-Uno data port, already tagged with the register number
   typedef struct packed {
      logic       rd;
      logic       wr;
      logic [7:0] regnum;        // Current value of the address latch
      logic [7:0] data;          // Byte from the CPU on writes
      logic       addr_changed;  // Address port was rewritten
   } reg_access_t;

   // ----------------------------------------------------------------------
   // Port map
   // ----------------------------------------------------------------------

   localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;  // Register select
   localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;  // Register data

   // Nobody drives the bus, the ULA would leave it floating high
   localparam logic [7:0] FLOATING_BUS = 8'hFF;

endpackage

/* logic/zxregs_pkg.sv */
package zxregs_pkg;

   // ----------------------------------------------------------------------
   // Register numbers behind the ZX-Uno data port
   // ----------------------------------------------------------------------

   localparam logic [7:0] REG_SCNDBLCTRL = 8'h0B;  // Scandoubler control
   localparam logic [7:0] REG_RASTERLINE = 8'h0C;  // Raster line, low byte
   localparam logic [7:0] REG_RASTERCTL  = 8'h0D;  // Raster control and status
   localparam logic [7:0] REG_SCRATCH    = 8'hFE;
   localparam logic [7:0] REG_COREID     = 8'hFF;

   // ----------------------------------------------------------------------
   // Register field layouts
   // ----------------------------------------------------------------------

   // Scandoubler control byte, bit 7 first
   typedef struct packed {
      logic       turbo_enable;      // Bit 7
      logic [1:0] unused;            // Kept so the byte reads back as written
      logic [2:0] freq_option;       // Bits 4:2, vertical refresh select
      logic       scanlines_enable;  // Bit 1
      logic       vga_enable;        // Bit 0
   } scndbl_t;

   // Raster interrupt settings handed to the ULA
   typedef struct packed {
      logic [8:0] line;              // Line that fires the interrupt
      logic       enable;
      logic       vretrace_disable;  // Masks the frame interrupt
   } raster_cfg_t;

   // ----------------------------------------------------------------------
   // Core identification
   // ----------------------------------------------------------------------

   localparam int COREID_LEN = 8;

   // First character in the top byte
   localparam logic [8*COREID_LEN-1:0] COREID_TEXT = "ZXREGS01";

endpackage

/* logic/zxuno_port_decode.sv */
`timescale 1ns/1ps

module zxuno_port_decode import zxbus_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  cpu_cycle_t  bus,
   output reg_access_t access,
   output rd_src_t     addr_src
);

   logic       addr_port_hit;  // Strobe on FC3B
   logic       data_port_hit;  // Strobe on FD3B
   logic [7:0] regaddr;        // Register selected by the last OUT to FC3B

   // Full 16-bit compare, no partial decoding
   assign addr_port_hit = bus.valid && (bus.addr == ZXUNO_ADDR_PORT);
   assign data_port_hit = bus.valid && (bus.addr == ZXUNO_DATA_PORT);

   // ----------------------------------------------------------------------
   // Register address latch
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         regaddr <= 8'h00;
      end else if (addr_port_hit && bus.write) begin
         regaddr <= bus.data;  // New number visible from the next cycle
      end
   end

   // ----------------------------------------------------------------------
   // Access to the register blocks
   // ----------------------------------------------------------------------

   always_comb begin
      access              = '0;
      access.regnum       = regaddr;   // Old number during an address write
      access.data         = bus.data;
      access.rd           = data_port_hit && !bus.write;
      access.wr           = data_port_hit && bus.write;
      access.addr_changed = addr_port_hit && bus.write;
   end

   // Reading FC3B gives back the latch itself
   always_comb begin
      addr_src.hit  = addr_port_hit && !bus.write;
      addr_src.data = regaddr;
   end

endmodule

/* logic/config_regs.sv */
`timescale 1ns/1ps

module config_regs import zxbus_pkg::*, zxregs_pkg::*; #(
   parameter logic [7:0] SCNDBL_DEFAULT = 8'h00
) (
   input  logic        clk,
   input  logic        reset,
   input  reg_access_t access,
   output rd_src_t     src,
   output scndbl_t     scndbl
);

   logic [7:0] scratch;
   scndbl_t    scndbl_q;

   logic sel_scratch;
   logic sel_scndbl;

   assign sel_scratch = (access.regnum == REG_SCRATCH);
   assign sel_scndbl  = (access.regnum == REG_SCNDBLCTRL);

   always_ff @(posedge clk) begin
      if (reset) begin
         scratch  <= 8'h00;
         scndbl_q <= scndbl_t'(SCNDBL_DEFAULT);  // Video mode at power up
      end else if (access.wr) begin
         if (sel_scratch) begin
            scratch <= access.data;
         end
         if (sel_scndbl) begin
            scndbl_q <= scndbl_t'(access.data);  // Whole byte, spare bits too
         end
      end
   end

   // Read side, straight from the stored bytes
   always_comb begin
      src.hit = access.rd && (sel_scratch || sel_scndbl);
      if (sel_scndbl) begin
         src.data = scndbl_q;
      end else begin
         src.data = scratch;
      end
   end

   assign scndbl = scndbl_q;  // Fields to the scandoubler

endmodule

/* logic/coreid_stream.sv */
`timescale 1ns/1ps

module coreid_stream import zxbus_pkg::*, zxregs_pkg::*; #(
   parameter int ID_LEN = COREID_LEN  // Characters sent, at most COREID_LEN
) (
   input  logic        clk,
   input  logic        reset,
   input  reg_access_t access,
   output rd_src_t     src
);

   localparam int PTR_W = $clog2(ID_LEN + 1);  // One extra state for "done"

   logic [PTR_W-1:0] ptr;       // Next character to hand out
   logic             id_read;
   logic             at_end;
   int               char_idx;  // Byte position inside COREID_TEXT

   assign id_read = access.rd && (access.regnum == REG_COREID);
   assign at_end  = (ptr >= PTR_W'(ID_LEN));

   always_ff @(posedge clk) begin
      if (reset) begin
         ptr <= '0;
      end else if (access.addr_changed) begin
         ptr <= '0;  // Any address rewrite restarts the string
      end else if (id_read && !at_end) begin
         ptr <= ptr + 1'b1;
      end
   end

   always_comb begin
      char_idx = COREID_LEN - 1 - int'(ptr);
      src.hit  = id_read;
      if (at_end) begin
         src.data = 8'h00;  // Terminator, repeated until rewound
      end else begin
         src.data = COREID_TEXT[8*char_idx +: 8];
      end
   end

endmodule

/* logic/rasterint_ctrl.sv */
`timescale 1ns/1ps

module rasterint_ctrl import zxbus_pkg::*, zxregs_pkg::*; (
   input  logic        clk,
   input  logic        reset,
   input  reg_access_t access,
   input  logic        raster_int_in_progress,
   output rd_src_t     src,
   output raster_cfg_t raster
);

   raster_cfg_t cfg;

   logic sel_line;
   logic sel_ctl;

   assign sel_line = (access.regnum == REG_RASTERLINE);
   assign sel_ctl  = (access.regnum == REG_RASTERCTL);

   always_ff @(posedge clk) begin
      if (reset) begin
         cfg <= '0;  // Raster interrupt off, line 0
      end else if (access.wr) begin
         if (sel_line) begin
            cfg.line[7:0] <= access.data;
         end
         if (sel_ctl) begin
            cfg.line[8]          <= access.data[0];
            cfg.enable           <= access.data[1];
            cfg.vretrace_disable <= access.data[2];
         end
      end
   end

   // ----------------------------------------------------------------------
   // Read back
   // ----------------------------------------------------------------------

   always_comb begin
      src.hit = access.rd && (sel_line || sel_ctl);
      if (sel_ctl) begin
         // Status in bit 7, settings in bits 2:0
         src.data = {raster_int_in_progress, 4'b0000,
                     cfg.vretrace_disable, cfg.enable, cfg.line[8]};
      end else begin
         src.data = cfg.line[7:0];
      end
   end

   assign raster = cfg;

endmodule

/* logic/zxuno_read_mux.sv */
`timescale 1ns/1ps

module zxuno_read_mux import zxbus_pkg::*; (
   input  logic       clk,
   input  logic       reset,
   input  cpu_cycle_t bus,
   input  rd_src_t    addr_src,
   input  rd_src_t    config_src,
   input  rd_src_t    coreid_src,
   input  rd_src_t    raster_src,
   output logic       rd_valid,
   output logic [7:0] rd_data
);

   logic       rd_strobe;  // Any IN cycle, claimed or not
   logic [7:0] sel_data;

   assign rd_strobe = bus.valid && !bus.write;

   // Fixed priority, first hit wins
   always_comb begin
      if (addr_src.hit) sel_data = addr_src.data;
      else if (config_src.hit) sel_data = config_src.data;
      else if (coreid_src.hit) sel_data = coreid_src.data;
      else if (raster_src.hit) sel_data = raster_src.data;
      else sel_data = FLOATING_BUS;
   end

   // ----------------------------------------------------------------------
   // Response stage
   // ----------------------------------------------------------------------

   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_strobe;  // One pulse per read strobe
      end
   end

   always_ff @(posedge clk) begin
      if (rd_strobe) begin
         rd_data <= sel_data;
      end
   end

endmodule

/* logic/zxuno_regbank.sv */
`timescale 1ns/1ps

module zxuno_regbank import zxbus_pkg::*, zxregs_pkg::*; #(
   parameter logic [7:0] SCNDBL_DEFAULT = 8'h00,
   parameter int         ID_LEN         = COREID_LEN
) (
   input  logic        clk,
   input  logic        reset,
   input  cpu_cycle_t  bus,
   input  logic        raster_int_in_progress,  // From the ULA
   output logic        rd_valid,
   output logic [7:0]  rd_data,
   output scndbl_t     scndbl,
   output raster_cfg_t raster
);

   reg_access_t access;  // Decoded data-port access, to every register block

   // One candidate per block, sorted out by the read mux
   rd_src_t addr_src;
   rd_src_t config_src;
   rd_src_t coreid_src;
   rd_src_t raster_src;

   zxuno_port_decode i_zxuno_port_decode (
      .clk      (clk),
      .reset    (reset),
      .bus      (bus),
      .access   (access),
      .addr_src (addr_src)
   );

   config_regs #(
      .SCNDBL_DEFAULT (SCNDBL_DEFAULT)
   ) i_config_regs (
      .clk    (clk),
      .reset  (reset),
      .access (access),
      .src    (config_src),
      .scndbl (scndbl)
   );

   coreid_stream #(
      .ID_LEN (ID_LEN)
   ) i_coreid_stream (
      .clk    (clk),
      .reset  (reset),
      .access (access),
      .src    (coreid_src)
   );

   rasterint_ctrl i_rasterint_ctrl (
      .clk                    (clk),
      .reset                  (reset),
      .access                 (access),
      .raster_int_in_progress (raster_int_in_progress),
      .src                    (raster_src),
      .raster                 (raster)
   );

   zxuno_read_mux i_zxuno_read_mux (
      .clk        (clk),
      .reset      (reset),
      .bus        (bus),
      .addr_src   (addr_src),
      .config_src (config_src),
      .coreid_src (coreid_src),
      .raster_src (raster_src),
      .rd_valid   (rd_valid),
      .rd_data    (rd_data)
   );

endmodule

/* tb/zxuno_regbank_assertions.sv */
`timescale 1ns/1ps

module zxuno_regbank_assertions import zxbus_pkg::*, zxregs_pkg::*; (
   input logic       clk,
   input logic       reset,
   input cpu_cycle_t bus,
   input logic       rd_valid,
   input scndbl_t    scndbl
);

   logic rd_strobe;
   logic wr_strobe;

   assign rd_strobe = bus.valid && !bus.write;
   assign wr_strobe = bus.valid && bus.write;

   // One response per read strobe, always in the next cycle
   rd_valid_follows_read: assert property (@(posedge clk) disable iff (reset)
      !$past(reset) |-> (rd_valid == $past(rd_strobe)))
      else $error("rd_valid does not match the read strobe of the previous cycle");

   rd_valid_low_in_reset: assert property (@(posedge clk)
      $past(reset) |-> !rd_valid)
      else $error("rd_valid high while in reset");

   // Only a bus write may move the scandoubler setting
   scndbl_needs_write: assert property (@(posedge clk) disable iff (reset)
      (!$past(reset) && !$stable(scndbl)) |-> $past(wr_strobe))
      else $error("scndbl changed without a write strobe");

endmodule

bind zxuno_regbank zxuno_regbank_assertions i_zxuno_regbank_assertions (
   .clk      (clk),
   .reset    (reset),
   .bus      (bus),
   .rd_valid (rd_valid),
   .scndbl   (scndbl)
);

/* tb/tb_zxuno_regbank.sv */
`timescale 1ns/1ps

module tb_zxuno_regbank import zxbus_pkg::*, zxregs_pkg::*; ();

   localparam logic [7:0] SCNDBL_INIT = 8'h01;  // VGA on at power up
   localparam string      STIM_FILE   = "tb/zxuno_stimulus.txt";

   logic        clk;
   logic        reset;
   cpu_cycle_t  bus;
   logic        raster_int_in_progress;
   logic        rd_valid;
   logic [7:0]  rd_data;
   scndbl_t     scndbl;
   raster_cfg_t raster;

   // One entry per line of the stimulus file
   logic [7:0]  op_list[$];
   logic [15:0] port_list[$];
   logic [7:0]  data_list[$];
   logic [15:0] exp_list[$];

   logic [7:0]  rd_expect_q[$];  // Expected bytes of reads in flight
   logic        read_pending = 1'b0;
   int          cycle_count = 0;
   int          cycle_limit = 50;
   logic [31:0] lcg_state = 32'hcc74097c;

   zxuno_regbank #(
      .SCNDBL_DEFAULT (SCNDBL_INIT),
      .ID_LEN         (COREID_LEN)
   ) i_zxuno_regbank (
      .clk                    (clk),
      .reset                  (reset),
      .bus                    (bus),
      .raster_int_in_progress (raster_int_in_progress),
      .rd_valid               (rd_valid),
      .rd_data                (rd_data),
      .scndbl                 (scndbl),
      .raster                 (raster)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;  // 8 ns period

   // ----------------------------------------------------------------------
   // Helpers
   // ----------------------------------------------------------------------

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Testbench failed");
      $fatal(1);
   endtask

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      assert (got === exp) else
         stop_on_error($sformatf("[FAIL] %0t ns %s: got %0h, expected %0h",
                                 $time, name, got, exp));
   endtask

   task automatic load_stimulus();
      int          fd;
      int          n;
      string       line;
      logic [7:0]  op;
      logic [15:0] port;
      logic [7:0]  data;
      logic [15:0] expv;
      fd = $fopen(STIM_FILE, "r");
      if (fd == 0) begin
         stop_on_error({"Could not open the stimulus file ", STIM_FILE});
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin  // Skip blanks and comments
               n = $sscanf(line, "%c %h %h %h", op, port, data, expv);
               if (n != 4) begin
                  stop_on_error({"Malformed line in the stimulus file: ", line});
               end else begin
                  op_list.push_back(op);
                  port_list.push_back(port);
                  data_list.push_back(data);
                  exp_list.push_back(expv);
               end
            end
         end
         $fclose(fd);
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #1;
   endtask

   task automatic drive_idle();
      next_cycle();
      bus = '0;
   endtask

   task automatic drive_strobe(input logic wr, input logic [15:0] port,
                               input logic [7:0] data);
      next_cycle();
      bus.valid = 1'b1;
      bus.write = wr;
      bus.addr  = port;
      bus.data  = data;
   endtask

   // scndbl as a byte, raster as {line, enable, vretrace_disable}
   task automatic check_outputs(input logic [7:0] exp_scndbl,
                                input logic [15:0] exp_raster);
      drive_idle();
      @(negedge clk);
      check_value("scndbl.turbo_enable", scndbl.turbo_enable, exp_scndbl[7]);
      check_value("scndbl.freq_option", scndbl.freq_option, exp_scndbl[4:2]);
      check_value("scndbl.scanlines_enable", scndbl.scanlines_enable, exp_scndbl[1]);
      check_value("scndbl.vga_enable", scndbl.vga_enable, exp_scndbl[0]);
      check_value("scndbl", scndbl, exp_scndbl);
      check_value("raster.line", raster.line, exp_raster[10:2]);
      check_value("raster.enable", raster.enable, exp_raster[1]);
      check_value("raster.vretrace_disable", raster.vretrace_disable, exp_raster[0]);
   endtask

   task automatic run_op(input logic [7:0] op, input logic [15:0] port,
                         input logic [7:0] data, input logic [15:0] expv);
      case (op)
         "W": drive_strobe(1'b1, port, data);
         "R", "B": begin
            drive_strobe(1'b0, port, 8'h00);
            rd_expect_q.push_back(expv[7:0]);
         end
         "C": check_outputs(data, expv);
         "I": begin
            drive_idle();
            raster_int_in_progress = data[0];  // Stands in for the ULA
         end
         default: stop_on_error($sformatf("Unknown operation code %c in the stimulus", op));
      endcase
   endtask

   // ----------------------------------------------------------------------
   // Read response checker and timeout
   // ----------------------------------------------------------------------

   always @(negedge clk) begin
      if (read_pending) begin
         assert (rd_valid === 1'b1) else
            stop_on_error($sformatf("rd_valid did not rise at %0t ns after a read strobe",
                                    $time));
         if (rd_expect_q.size() == 0) begin
            stop_on_error("A read response came with no expected value queued");
         end else begin
            check_value("rd_data", rd_data, rd_expect_q.pop_front());
         end
      end
      read_pending = bus.valid && !bus.write;  // Sampled at the next rising edge
   end

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count > cycle_limit) begin
         stop_on_error($sformatf("The run timed out after %0d cycles", cycle_count));
      end
   end

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------

   initial begin
      int         i;
      logic [1:0] idle;
      reset                  = 1'b1;
      bus                    = '0;
      raster_int_in_progress = 1'b0;
      load_stimulus();
      cycle_limit = op_list.size() * 6 + 50;
      repeat (3) @(posedge clk);
      #1 reset = 1'b0;

      for (i = 0; i < op_list.size(); i++) begin
         // B and C follow the previous operation directly
         if (op_list[i] != "B" && op_list[i] != "C") begin
            lcg_state = lcg_next(lcg_state);
            idle = lcg_state[17:16];
            repeat (idle) drive_idle();
         end
         run_op(op_list[i], port_list[i], data_list[i], exp_list[i]);
      end
      drive_idle();
      repeat (2) @(negedge clk);  // Let the last response through

      if (rd_expect_q.size() == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         stop_on_error($sformatf("%0d read responses never arrived", rd_expect_q.size()));
      end
   end

endmodule

/* tb/zxuno_stimulus.txt */
# op port data expect, all hex. W write, R read, B read with no idle cycle before it,
# C check scndbl == data and raster {line,enable,vretrace_disable} == expect, I in-progress = data[0]
C 0000 01 000
W FC3B 0B 00
R FD3B 00 01
W FC3B 0C 00
R FD3B 00 00
W FC3B 0D 00
R FD3B 00 00
W FC3B FE 00
R FD3B 00 00
R FC3B 00 FE
R 00FE 00 FF
W FD3B A5 00
R FD3B 00 A5
W FC3B 0B 00
W FD3B 9E 00
C 0000 9E 000
R FD3B 00 9E
W FC3B FF 00
R FD3B 00 5A
B FD3B 00 58
B FD3B 00 52
R FD3B 00 45
R FD3B 00 47
B FD3B 00 53
R FD3B 00 30
B FD3B 00 31
R FD3B 00 00
B FD3B 00 00
W FC3B FF 00
R FD3B 00 5A
B FD3B 00 58
W FC3B 0C 00
W FD3B 2D 00
W FC3B 0D 00
W FD3B 07 00
C 0000 9E 4B7
I 0000 01 000
R FD3B 00 87
B FC3B 00 0D
B 1234 00 FF
I 0000 00 000
R FD3B 00 07
W FD3B 02 00
C 0000 9E 0B6
W FC3B 0C 00
R FD3B 00 2D

/* zxuno_regbank.f */
logic/zxbus_pkg.sv
logic/zxregs_pkg.sv
logic/zxuno_port_decode.sv
logic/config_regs.sv
logic/coreid_stream.sv
logic/rasterint_ctrl.sv
logic/zxuno_read_mux.sv
logic/zxuno_regbank.sv
tb/zxuno_regbank_assertions.sv
tb/tb_zxuno_regbank.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_zxuno_regbank
FILELIST   ?= zxuno_regbank.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
PASS_MSG   ?= Testbench passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
